// File: src/kernel_pkg.sv
package kernel_pkg;

  typedef logic [14:0]  host_addr_t; // byte address
  typedef logic [31:0]  host_word_t;
  typedef logic [3:0]   host_strb_t;
  typedef logic [255:0] stage_t;

  typedef logic [63:0]  axi_addr_t;
  typedef logic [127:0] axi_data_t;
  typedef logic [15:0]  axi_strb_t;
  typedef logic [3:0]   axi_id_t;
  typedef logic [1:0]   axi_resp_t;
  typedef logic [2:0]   axi_size_t;
  typedef logic [7:0]   axi_len_t;

  // fifo entries, low bits of the staging buffer
  typedef struct packed {
    axi_size_t size;
    axi_addr_t addr;
  } aw_entry_t;

  typedef struct packed {
    axi_strb_t strb;
    axi_data_t data;
  } w_entry_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_entry_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
    axi_data_t data;
  } r_entry_t;

  // channel payloads
  typedef struct packed {
    axi_addr_t  addr;
    logic [1:0] burst;
    logic [3:0] cache;
    axi_id_t    id;
    axi_len_t   len;
    logic       lock;
    logic [2:0] prot;
    logic [3:0] qos;
    axi_size_t  size;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
    axi_data_t data;
    logic      last;
  } axi_r_t;

  localparam axi_id_t    AWID_FIXED = 4'd1;
  localparam axi_id_t    ARID_FIXED = 4'd2;
  localparam logic [1:0] BURST_INCR = 2'd1;
  localparam axi_resp_t  RESP_OKAY  = 2'd0;

  localparam host_addr_t REG_DATA0        = 15'h00;
  localparam host_addr_t REG_DATA1        = 15'h04;
  localparam host_addr_t REG_DATA2        = 15'h08;
  localparam host_addr_t REG_DATA3        = 15'h0c;
  localparam host_addr_t REG_DATA4        = 15'h10;
  localparam host_addr_t REG_DATA5        = 15'h14;
  localparam host_addr_t REG_DATA6        = 15'h18;
  localparam host_addr_t REG_DATA7        = 15'h1c;
  localparam host_addr_t REG_AW_PUSH      = 15'h20;
  localparam host_addr_t REG_W_PUSH       = 15'h30;
  localparam host_addr_t REG_AR_PUSH      = 15'h40;
  localparam host_addr_t REG_B_STATUS     = 15'h50;
  localparam host_addr_t REG_B_POP        = 15'h54;
  localparam host_addr_t REG_R_STATUS     = 15'h60;
  localparam host_addr_t REG_R_POP        = 15'h64;
  localparam host_addr_t REG_LINK_RST_ON  = 15'hc0;
  localparam host_addr_t REG_LINK_RST_OFF = 15'hc4;

endpackage

// File: src/fifo_bp.sv
`timescale 1ns/1ps

module fifo_bp #(
  parameter int  LOG2_DEPTH = 9,
  parameter type T          = logic [7:0]
) (
  input  logic clk,
  input  logic rstn,
  input  logic wvalid,
  input  T     wdata,
  output logic wready,
  output logic rvalid,
  output T     rdata,
  input  logic rready
);

  localparam int DEPTH = 1 << LOG2_DEPTH;

  T                      mem [DEPTH];
  logic [LOG2_DEPTH-1:0] wptr;
  logic [LOG2_DEPTH-1:0] rptr;
  logic [LOG2_DEPTH:0]   count; // occupancy
  logic                  do_push;
  logic                  do_pop;

  assign wready  = count != (LOG2_DEPTH + 1)'(DEPTH);
  assign rvalid  = count != '0;
  assign rdata   = mem[rptr]; // head entry
  assign do_push = wvalid && wready;
  assign do_pop  = rvalid && rready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wptr <= wptr + 1'b1; // wraps at depth
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
      count <= count + (LOG2_DEPTH + 1)'(do_push) - (LOG2_DEPTH + 1)'(do_pop);
    end
  end

endmodule

// File: src/host_regs.sv
`timescale 1ns/1ps

module host_regs import kernel_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       host_en,
  input  host_strb_t host_we,
  input  host_addr_t host_addr,
  input  host_word_t host_din,
  output host_word_t host_dout,
  output logic       aw_push,
  output logic       w_push,
  output logic       ar_push,
  output logic       b_pop,
  output logic       r_pop,
  output aw_entry_t  aw_entry,
  output aw_entry_t  ar_entry,
  output w_entry_t   w_entry,
  input  logic       b_valid,
  input  logic       r_valid,
  input  b_entry_t   b_head,
  input  r_entry_t   r_head,
  output logic       ocu_rstn
);

  stage_t     stage;
  logic       ocu_rstn_sw;
  logic       wr;
  logic       is_data;
  logic [2:0] wsel;

  assign wr      = host_en && host_we != '0;
  // 0x00..0x1c, word aligned
  assign is_data = (host_addr & ~host_addr_t'(15'h1c)) == REG_DATA0;
  assign wsel    = host_addr[4:2];

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_push     <= 1'b0;
      w_push      <= 1'b0;
      ar_push     <= 1'b0;
      b_pop       <= 1'b0;
      r_pop       <= 1'b0;
      ocu_rstn    <= 1'b0;
      ocu_rstn_sw <= 1'b1; // link out of reset by default
      host_dout   <= '0;
      stage       <= '0;
    end else begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      ar_push  <= 1'b0;
      b_pop    <= 1'b0;
      r_pop    <= 1'b0;
      ocu_rstn <= ocu_rstn_sw;

      if (wr) begin
        if (is_data) begin
          stage[wsel*32 +: 32] <= host_din;
        end else begin
          case (host_addr)
            REG_AW_PUSH: aw_push <= 1'b1;
            REG_W_PUSH:  w_push  <= 1'b1;
            REG_AR_PUSH: ar_push <= 1'b1;
            REG_B_POP: begin
              if (b_valid) begin // empty fifo leaves buffer alone
                b_pop <= 1'b1;
                stage <= stage_t'(b_head);
              end
            end
            REG_R_POP: begin
              if (r_valid) begin
                r_pop <= 1'b1;
                stage <= stage_t'(r_head);
              end
            end
            REG_LINK_RST_ON:  ocu_rstn_sw <= 1'b0;
            REG_LINK_RST_OFF: ocu_rstn_sw <= 1'b1;
            default: ;
          endcase
        end
      end else begin
        if (is_data) begin
          host_dout <= stage[wsel*32 +: 32];
        end else if (host_addr == REG_B_STATUS) begin
          host_dout <= {31'b0, b_valid};
        end else if (host_addr == REG_R_STATUS) begin
          host_dout <= {31'b0, r_valid};
        end
      end
    end
  end

  // entries latched with the strobe so later data writes can't race them
  always_ff @(posedge clk) begin
    if (wr && host_addr == REG_AW_PUSH) begin
      aw_entry <= stage[$bits(aw_entry_t)-1:0];
    end
    if (wr && host_addr == REG_W_PUSH) begin
      w_entry <= stage[$bits(w_entry_t)-1:0];
    end
    if (wr && host_addr == REG_AR_PUSH) begin
      ar_entry <= stage[$bits(aw_entry_t)-1:0];
    end
  end

endmodule

// File: src/k2o_master.sv
`timescale 1ns/1ps

module k2o_master import kernel_pkg::*; #(
  parameter int LOG2_DEPTH = 9
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      aw_push,
  input  logic      w_push,
  input  logic      ar_push,
  input  aw_entry_t aw_entry,
  input  w_entry_t  w_entry,
  input  aw_entry_t ar_entry,
  input  logic      b_pop,
  input  logic      r_pop,
  output logic      b_valid,
  output logic      r_valid,
  output b_entry_t  b_head,
  output r_entry_t  r_head,
  output axi_ax_t   k2o_aw,
  output logic      k2o_awvalid,
  input  logic      k2o_awready,
  output axi_w_t    k2o_w,
  output logic      k2o_wvalid,
  input  logic      k2o_wready,
  output axi_ax_t   k2o_ar,
  output logic      k2o_arvalid,
  input  logic      k2o_arready,
  input  axi_b_t    k2o_b,
  input  logic      k2o_bvalid,
  output logic      k2o_bready,
  input  axi_r_t    k2o_r,
  input  logic      k2o_rvalid,
  output logic      k2o_rready
);

  aw_entry_t aw_head;
  w_entry_t  w_head;
  aw_entry_t ar_head;
  b_entry_t  b_in;
  r_entry_t  r_in;

  // single beat INCR, everything else zero
  function automatic axi_ax_t ax_from_entry(aw_entry_t e, axi_id_t id);
    axi_ax_t ax;
    ax       = '0;
    ax.addr  = e.addr;
    ax.size  = e.size;
    ax.id    = id;
    ax.burst = BURST_INCR;
    ax.len   = '0;
    return ax;
  endfunction

  fifo_bp #(.LOG2_DEPTH(LOG2_DEPTH), .T(aw_entry_t)) aw_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(aw_push), .wdata(aw_entry), .wready(),
    .rvalid(k2o_awvalid), .rdata(aw_head), .rready(k2o_awready)
  );

  fifo_bp #(.LOG2_DEPTH(LOG2_DEPTH), .T(w_entry_t)) w_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(w_push), .wdata(w_entry), .wready(),
    .rvalid(k2o_wvalid), .rdata(w_head), .rready(k2o_wready)
  );

  fifo_bp #(.LOG2_DEPTH(LOG2_DEPTH), .T(aw_entry_t)) ar_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(ar_push), .wdata(ar_entry), .wready(),
    .rvalid(k2o_arvalid), .rdata(ar_head), .rready(k2o_arready)
  );

  fifo_bp #(.LOG2_DEPTH(LOG2_DEPTH), .T(b_entry_t)) b_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(k2o_bvalid), .wdata(b_in), .wready(k2o_bready),
    .rvalid(b_valid), .rdata(b_head), .rready(b_pop)
  );

  fifo_bp #(.LOG2_DEPTH(LOG2_DEPTH), .T(r_entry_t)) r_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(k2o_rvalid), .wdata(r_in), .wready(k2o_rready),
    .rvalid(r_valid), .rdata(r_head), .rready(r_pop)
  );

  always_comb begin
    k2o_aw = ax_from_entry(aw_head, AWID_FIXED);
    k2o_ar = ax_from_entry(ar_head, ARID_FIXED);

    k2o_w.data = w_head.data;
    k2o_w.strb = w_head.strb;
    k2o_w.last = 1'b1; // one beat per burst

    b_in.id   = k2o_b.id;
    b_in.resp = k2o_b.resp;

    r_in.id   = k2o_r.id; // rlast not kept, bursts are single beat
    r_in.resp = k2o_r.resp;
    r_in.data = k2o_r.data;
  end

endmodule

// File: src/kernel_top.sv
`timescale 1ns/1ps

module kernel_top import kernel_pkg::*; #(
  parameter int LOG2_DEPTH = 9
) (
  input  logic       clk,
  input  logic       rstn,
  output logic       ocu_rstn,
  input  logic       host_en,
  input  host_strb_t host_we,
  input  host_addr_t host_addr,
  input  host_word_t host_din,
  output host_word_t host_dout,
  output axi_ax_t    k2o_aw,
  output logic       k2o_awvalid,
  input  logic       k2o_awready,
  output axi_w_t     k2o_w,
  output logic       k2o_wvalid,
  input  logic       k2o_wready,
  output axi_ax_t    k2o_ar,
  output logic       k2o_arvalid,
  input  logic       k2o_arready,
  input  axi_b_t     k2o_b,
  input  logic       k2o_bvalid,
  output logic       k2o_bready,
  input  axi_r_t     k2o_r,
  input  logic       k2o_rvalid,
  output logic       k2o_rready
);

  logic      aw_push;
  logic      w_push;
  logic      ar_push;
  logic      b_pop;
  logic      r_pop;
  aw_entry_t aw_entry;
  aw_entry_t ar_entry;
  w_entry_t  w_entry;
  logic      b_valid;
  logic      r_valid;
  b_entry_t  b_head;
  r_entry_t  r_head;

  host_regs u_regs (
    .clk(clk), .rstn(rstn),
    .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
    .host_din(host_din), .host_dout(host_dout),
    .aw_push(aw_push), .w_push(w_push), .ar_push(ar_push),
    .b_pop(b_pop), .r_pop(r_pop),
    .aw_entry(aw_entry), .ar_entry(ar_entry), .w_entry(w_entry),
    .b_valid(b_valid), .r_valid(r_valid), .b_head(b_head), .r_head(r_head),
    .ocu_rstn(ocu_rstn)
  );

  k2o_master #(.LOG2_DEPTH(LOG2_DEPTH)) u_master (
    .clk(clk), .rstn(rstn),
    .aw_push(aw_push), .w_push(w_push), .ar_push(ar_push),
    .aw_entry(aw_entry), .w_entry(w_entry), .ar_entry(ar_entry),
    .b_pop(b_pop), .r_pop(r_pop),
    .b_valid(b_valid), .r_valid(r_valid), .b_head(b_head), .r_head(r_head),
    .k2o_aw(k2o_aw), .k2o_awvalid(k2o_awvalid), .k2o_awready(k2o_awready),
    .k2o_w(k2o_w), .k2o_wvalid(k2o_wvalid), .k2o_wready(k2o_wready),
    .k2o_ar(k2o_ar), .k2o_arvalid(k2o_arvalid), .k2o_arready(k2o_arready),
    .k2o_b(k2o_b), .k2o_bvalid(k2o_bvalid), .k2o_bready(k2o_bready),
    .k2o_r(k2o_r), .k2o_rvalid(k2o_rvalid), .k2o_rready(k2o_rready)
  );

endmodule

// File: tests/tb_kernel.sv
`timescale 1ns/1ps

module tb_kernel import kernel_pkg::*;;

  logic       clk = 1'b0;
  logic       rstn;
  logic       ocu_rstn;
  logic       host_en;
  host_strb_t host_we;
  host_addr_t host_addr;
  host_word_t host_din;
  host_word_t host_dout;
  axi_ax_t    k2o_aw;
  logic       k2o_awvalid;
  logic       k2o_awready = 1'b0;
  axi_w_t     k2o_w;
  logic       k2o_wvalid;
  logic       k2o_wready = 1'b0;
  axi_ax_t    k2o_ar;
  logic       k2o_arvalid;
  logic       k2o_arready = 1'b0;
  axi_b_t     k2o_b = '0;
  logic       k2o_bvalid = 1'b0;
  logic       k2o_bready;
  axi_r_t     k2o_r = '0;
  logic       k2o_rvalid = 1'b0;
  logic       k2o_rready;

  stage_t  stage_m; // expected staging buffer
  axi_ax_t aw_exp[$];
  axi_w_t  w_exp[$];
  axi_ax_t ar_exp[$];
  axi_b_t  b_to_send[$];
  axi_b_t  b_acc[$]; // accepted by the DUT, in order
  axi_r_t  r_to_send[$];
  axi_r_t  r_acc[$];
  logic    b_taken = 1'b0;
  logic    r_taken = 1'b0;
  int      checks = 0;
  int      errors = 0;
  int      timeouts = 0;

  kernel_top #(.LOG2_DEPTH(3)) DUT (
    .clk(clk), .rstn(rstn), .ocu_rstn(ocu_rstn),
    .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
    .host_din(host_din), .host_dout(host_dout),
    .k2o_aw(k2o_aw), .k2o_awvalid(k2o_awvalid), .k2o_awready(k2o_awready),
    .k2o_w(k2o_w), .k2o_wvalid(k2o_wvalid), .k2o_wready(k2o_wready),
    .k2o_ar(k2o_ar), .k2o_arvalid(k2o_arvalid), .k2o_arready(k2o_arready),
    .k2o_b(k2o_b), .k2o_bvalid(k2o_bvalid), .k2o_bready(k2o_bready),
    .k2o_r(k2o_r), .k2o_rvalid(k2o_rvalid), .k2o_rready(k2o_rready)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic check_word(host_word_t got, host_word_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ax(axi_ax_t got, axi_ax_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_w(axi_w_t got, axi_w_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fail_wait(string what);
    timeouts++;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic tick(int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic host_write(host_addr_t a, host_word_t d);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = a;
    host_din  = d;
    @(negedge clk);
    host_en = 1'b0;
    host_we = '0;
  endtask

  task automatic host_read(host_addr_t a, output host_word_t d);
    host_en   = 1'b1;
    host_we   = '0;
    host_addr = a;
    @(negedge clk); // host_dout updated at the rising edge
    d       = host_dout;
    host_en = 1'b0;
  endtask

  task automatic write_data(int i, host_word_t d);
    host_write(host_addr_t'(4 * i), d);
    stage_m[32*i +: 32] = d;
  endtask

  task automatic check_stage(string what);
    host_word_t v;
    for (int i = 0; i < 8; i++) begin
      host_read(host_addr_t'(4 * i), v);
      check_word(v, stage_m[32*i +: 32], $sformatf("%s word %0d", what, i));
    end
  endtask

  // address and size from the buffer, single beat INCR
  function automatic axi_ax_t expected_ax(stage_t s, axi_id_t id);
    axi_ax_t ax;
    ax       = '0;
    ax.addr  = s[63:0];
    ax.size  = s[66:64];
    ax.id    = id;
    ax.burst = 2'd1;
    return ax;
  endfunction

  function automatic axi_w_t expected_w(stage_t s);
    axi_w_t w;
    w.data = s[127:0];
    w.strb = s[143:128];
    w.last = 1'b1;
    return w;
  endfunction

  function automatic axi_b_t random_b();
    axi_b_t b;
    b.id   = axi_id_t'($urandom);
    b.resp = axi_resp_t'($urandom);
    return b;
  endfunction

  function automatic axi_r_t random_r();
    axi_r_t r;
    r.id   = axi_id_t'($urandom);
    r.resp = axi_resp_t'($urandom);
    r.data = {$urandom, $urandom, $urandom, $urandom};
    r.last = 1'b1;
    return r;
  endfunction

  // until every issue queue holds fewer than limit entries
  task automatic wait_issue(int limit);
    int n;
    n = 0;
    while ((aw_exp.size() >= limit || w_exp.size() >= limit || ar_exp.size() >= limit)
           && n < 400) begin
      tick(1);
      n++;
    end
    if (n == 400) fail_wait("the AXI slave model to take issued beats");
  endtask

  task automatic wait_status(host_addr_t a, string name);
    host_word_t v;
    int         n;
    n = 0;
    v = '0;
    while (v != 32'd1 && n < 200) begin
      host_read(a, v);
      n++;
    end
    if (v != 32'd1) fail_wait({name, " status to read 1"});
  endtask

  task automatic pop_b();
    axi_b_t b;
    wait_status(REG_B_STATUS, "B");
    host_write(REG_B_POP, '0);
    tick(3);
    if (b_acc.size() == 0) begin
      errors++;
      $display("a B entry was popped that the slave model never sent");
    end else begin
      b            = b_acc.pop_front();
      stage_m      = '0;
      stage_m[5:0] = {b.id, b.resp};
    end
    check_stage("B pop");
  endtask

  task automatic pop_r();
    axi_r_t r;
    wait_status(REG_R_STATUS, "R");
    host_write(REG_R_POP, '0);
    tick(3);
    if (r_acc.size() == 0) begin
      errors++;
      $display("an R entry was popped that the slave model never sent");
    end else begin
      r                = r_acc.pop_front();
      stage_m          = '0;
      stage_m[127:0]   = r.data;
      stage_m[133:128] = {r.id, r.resp};
    end
    check_stage("R pop");
  endtask

  task automatic wait_ocu(logic v);
    int n;
    n = 0;
    while (ocu_rstn !== v && n < 2) begin
      tick(1);
      n++;
    end
    check_word({31'b0, ocu_rstn}, {31'b0, v}, "ocu_rstn");
  endtask

  // slave model, ready and valid change on the falling edge
  always @(negedge clk) begin
    logic    rdy;
    axi_ax_t ax_e;
    axi_w_t  w_e;
    if (rstn) begin
      rdy = ($urandom % 2) == 0;
      k2o_awready = rdy;
      if (k2o_awvalid && rdy) begin // taken at the next rising edge
        if (aw_exp.size() == 0) begin
          errors++;
          $display("the DUT issued an AW beat that was never pushed");
        end else begin
          ax_e = aw_exp.pop_front();
          check_ax(k2o_aw, ax_e, "AW beat");
        end
      end
      rdy = ($urandom % 2) == 0;
      k2o_wready = rdy;
      if (k2o_wvalid && rdy) begin
        if (w_exp.size() == 0) begin
          errors++;
          $display("the DUT issued a W beat that was never pushed");
        end else begin
          w_e = w_exp.pop_front();
          check_w(k2o_w, w_e, "W beat");
        end
      end
      rdy = ($urandom % 2) == 0;
      k2o_arready = rdy;
      if (k2o_arvalid && rdy) begin
        if (ar_exp.size() == 0) begin
          errors++;
          $display("the DUT issued an AR beat that was never pushed");
        end else begin
          ax_e = ar_exp.pop_front();
          check_ax(k2o_ar, ax_e, "AR beat");
        end
      end

      if (b_taken) k2o_bvalid = 1'b0;
      if (!k2o_bvalid && b_to_send.size() != 0 && ($urandom % 3) != 0) begin
        k2o_b      = b_to_send.pop_front();
        k2o_bvalid = 1'b1;
      end
      b_taken = k2o_bvalid && k2o_bready; // held while bready is low
      if (b_taken) b_acc.push_back(k2o_b);

      if (r_taken) k2o_rvalid = 1'b0;
      if (!k2o_rvalid && r_to_send.size() != 0 && ($urandom % 3) != 0) begin
        k2o_r      = r_to_send.pop_front();
        k2o_rvalid = 1'b1;
      end
      r_taken = k2o_rvalid && k2o_rready;
      if (r_taken) r_acc.push_back(k2o_r);
    end
  end

  initial begin
    host_word_t v;
    int         kind;
    int         n;
    void'($urandom(93));
    rstn      = 1'b0;
    host_en   = 1'b0;
    host_we   = '0;
    host_addr = '0;
    host_din  = '0;
    stage_m   = '0;
    repeat (2) @(negedge clk);
    rstn = 1'b1;
    tick(2);
    check_word({31'b0, ocu_rstn}, 32'd1, "ocu_rstn after reset");

    for (int i = 0; i < 8; i++) write_data(i, $urandom);
    check_stage("staging readback");

    // random AW, W and AR pushes against a stalling slave
    for (int t = 0; t < 24; t++) begin
      for (int i = 0; i < 5; i++) write_data(i, $urandom);
      kind = $urandom % 3;
      wait_issue(6);
      case (kind)
        0: begin
          aw_exp.push_back(expected_ax(stage_m, 4'd1));
          host_write(REG_AW_PUSH, '0);
        end
        1: begin
          w_exp.push_back(expected_w(stage_m));
          host_write(REG_W_PUSH, '0);
        end
        default: begin
          ar_exp.push_back(expected_ax(stage_m, 4'd2));
          host_write(REG_AR_PUSH, '0);
        end
      endcase
    end
    wait_issue(1);

    for (int t = 0; t < 6; t++) begin
      b_to_send.push_back(random_b());
      r_to_send.push_back(random_r());
    end
    for (int t = 0; t < 6; t++) pop_b();
    for (int t = 0; t < 6; t++) pop_r();
    host_read(REG_B_STATUS, v);
    check_word(v, '0, "B status after drain");
    host_read(REG_R_STATUS, v);
    check_word(v, '0, "R status after drain");
    host_write(REG_B_POP, '0);
    tick(3);
    check_stage("B pop while empty");
    host_write(REG_R_POP, '0);
    tick(3);
    check_stage("R pop while empty");

    // overfill the B capture FIFO
    for (int t = 0; t < 12; t++) b_to_send.push_back(random_b());
    n = 0;
    while (k2o_bready && n < 200) begin
      tick(1);
      n++;
    end
    if (n == 200) fail_wait("bready to fall");
    tick(4);
    check_word(host_word_t'(b_acc.size()), 32'd8, "B beats held in a full FIFO");
    for (int t = 0; t < 12; t++) pop_b();
    host_read(REG_B_STATUS, v);
    check_word(v, '0, "B status after overfill drain");

    host_write(REG_LINK_RST_ON, '0);
    wait_ocu(1'b0);
    host_write(REG_LINK_RST_OFF, '0);
    wait_ocu(1'b1);

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: kernel.f
src/kernel_pkg.sv
src/fifo_bp.sv
src/host_regs.sv
src/k2o_master.sv
src/kernel_top.sv
tests/tb_kernel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_kernel
FILELIST  ?= kernel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
SRCS      := $(wildcard src/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
